// ==== hw/scalar_pkg.sv ====
// Shared widths, instruction format, opcodes and port structs of the scalar core
package scalar_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_IDX_W  = 5;
	localparam int BANK_DEPTH = 16;
	localparam int IMM_W      = 11;

	// Opcode is {type, class, code}
	typedef enum logic [5:0] {
		OP_NOP   = 6'b00_00_00,
		OP_ADD   = 6'b00_01_00,
		OP_SUB   = 6'b00_01_01,
		OP_ADDI  = 6'b00_01_10,
		OP_AND   = 6'b00_10_00,
		OP_XOR   = 6'b00_10_01,
		OP_MOVS  = 6'b00_11_11,
		OP_TERM  = 6'b01_01_11,
		OP_CMPLT = 6'b10_00_01,
		OP_JMP   = 6'b11_01_01,
		OP_BRC   = 6'b11_10_01
	} op_t;

	typedef struct packed {
		op_t                  op;
		logic [REG_IDX_W-1:0] dst;
		logic [REG_IDX_W-1:0] src1;
		logic [REG_IDX_W-1:0] src2;
		logic [IMM_W-1:0]     imm;
	} instr_t;

	typedef struct packed {
		logic [REG_IDX_W-1:0] src1;
		logic [REG_IDX_W-1:0] src2;
	} rf_read_t;

	typedef struct packed {
		logic                 we;
		logic [REG_IDX_W-1:0] dst;
		logic [DATA_W-1:0]    data;
	} rf_write_t;

	typedef struct packed {
		logic             redirect;
		logic [IMM_W-1:0] target;
		logic             term;
	} flow_t;

	//////////////////////////////////////////////////
	// Wishbone classic host port
	//////////////////////////////////////////////////
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [1:0]        adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

	localparam logic [1:0] REG_CONTROL  = 2'd0;
	localparam logic [1:0] REG_START_PC = 2'd1;
	localparam logic [1:0] REG_STATUS   = 2'd2;
	localparam logic [1:0] REG_SCALAR   = 2'd3;

endpackage

// ==== hw/reg_bank.sv ====
// Register bank with two synchronous read ports and one write port
`timescale 1ns/1ps

module reg_bank (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [scalar_pkg::REG_IDX_W-2:0]  rd_idx1,
	input  logic [scalar_pkg::REG_IDX_W-2:0]  rd_idx2,
	output logic [scalar_pkg::DATA_W-1:0]     rd_data1,
	output logic [scalar_pkg::DATA_W-1:0]     rd_data2,
	input  logic                              we,
	input  logic [scalar_pkg::REG_IDX_W-2:0]  wr_idx,
	input  logic [scalar_pkg::DATA_W-1:0]     wr_data
);
	import scalar_pkg::*;

	logic [DATA_W-1:0] regs [BANK_DEPTH];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BANK_DEPTH; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Old value on a same-cycle read and write
	always_ff @(posedge clock) begin
		rd_data1 <= regs[rd_idx1];
		rd_data2 <= regs[rd_idx2];
	end

endmodule

// ==== hw/reg_file.sv ====
// Register file built from an even and an odd bank, selected by index bit 0
`timescale 1ns/1ps

module reg_file (
	input  logic                           clock,
	input  logic                           reset,
	input  scalar_pkg::rf_read_t           rf_read,
	input  scalar_pkg::rf_write_t          rf_write,
	output logic [scalar_pkg::DATA_W-1:0]  src1_data,
	output logic [scalar_pkg::DATA_W-1:0]  src2_data
);
	import scalar_pkg::*;

	logic [DATA_W-1:0] even_data1;
	logic [DATA_W-1:0] even_data2;
	logic [DATA_W-1:0] odd_data1;
	logic [DATA_W-1:0] odd_data2;

	// Bank select follows the registered read data
	logic sel1_odd;
	logic sel2_odd;

	always_ff @(posedge clock) begin
		if (reset) begin
			sel1_odd <= 1'b0;
			sel2_odd <= 1'b0;
		end else begin
			sel1_odd <= rf_read.src1[0];
			sel2_odd <= rf_read.src2[0];
		end
	end

	assign src1_data = sel1_odd ? odd_data1 : even_data1;
	assign src2_data = sel2_odd ? odd_data2 : even_data2;

	reg_bank u_even (
		.clock    (clock),
		.reset    (reset),
		.rd_idx1  (rf_read.src1[REG_IDX_W-1:1]),
		.rd_idx2  (rf_read.src2[REG_IDX_W-1:1]),
		.rd_data1 (even_data1),
		.rd_data2 (even_data2),
		.we       (rf_write.we & ~rf_write.dst[0]),
		.wr_idx   (rf_write.dst[REG_IDX_W-1:1]),
		.wr_data  (rf_write.data)
	);

	reg_bank u_odd (
		.clock    (clock),
		.reset    (reset),
		.rd_idx1  (rf_read.src1[REG_IDX_W-1:1]),
		.rd_idx2  (rf_read.src2[REG_IDX_W-1:1]),
		.rd_data1 (odd_data1),
		.rd_data2 (odd_data2),
		.we       (rf_write.we & rf_write.dst[0]),
		.wr_idx   (rf_write.dst[REG_IDX_W-1:1]),
		.wr_data  (rf_write.data)
	);

endmodule

// ==== hw/exec_unit.sv ====
// Scalar ALU with condition register, branch decision and termination
`timescale 1ns/1ps

module exec_unit #(
	parameter int INSTR_ADDR_W = 10
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           exec_valid,
	input  scalar_pkg::instr_t             exec_instr,
	input  logic [scalar_pkg::DATA_W-1:0]  src1_data,
	input  logic [scalar_pkg::DATA_W-1:0]  src2_data,
	output scalar_pkg::rf_write_t          rf_write,
	output scalar_pkg::flow_t              flow,
	output logic                           scalar_we,
	output logic [scalar_pkg::DATA_W-1:0]  scalar_data
);
	import scalar_pkg::*;

	logic              cond;
	logic              cond_we;
	logic              cond_next;
	logic              movs;
	logic [DATA_W-1:0] imm_ext;
	logic [IMM_W-1:0]  target;
	rf_write_t         wr_next;
	flow_t             flow_next;

	assign imm_ext = {{(DATA_W-IMM_W){exec_instr.imm[IMM_W-1]}}, exec_instr.imm};

	// Targets wrap with the PC
	assign target = IMM_W'(exec_instr.imm[INSTR_ADDR_W-1:0]);

	//////////////////////////////////////////////////
	// Decode and ALU
	//////////////////////////////////////////////////
	always_comb begin
		wr_next     = '0;
		wr_next.dst = exec_instr.dst;
		flow_next   = '0;
		cond_we     = 1'b0;
		cond_next   = $signed(src1_data) < $signed(src2_data);
		movs        = 1'b0;
		case (exec_instr.op)
			OP_ADD:   wr_next.data = src1_data + src2_data;
			OP_SUB:   wr_next.data = src1_data - src2_data;
			OP_AND:   wr_next.data = src1_data & src2_data;
			OP_XOR:   wr_next.data = src1_data ^ src2_data;
			OP_ADDI:  wr_next.data = src1_data + imm_ext;
			OP_CMPLT: cond_we = 1'b1;
			OP_BRC: begin
				flow_next.redirect = cond;
				flow_next.target   = target;
			end
			OP_JMP: begin
				flow_next.redirect = 1'b1;
				flow_next.target   = target;
			end
			OP_MOVS:  movs = 1'b1;
			OP_TERM:  flow_next.term = 1'b1;
			default: ;
		endcase
		case (exec_instr.op)
			OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: wr_next.we = 1'b1;
			default: wr_next.we = 1'b0;
		endcase
	end

	// Results held for the write-back step only
	always_ff @(posedge clock) begin
		if (reset) begin
			rf_write    <= '0;
			flow        <= '0;
			scalar_we   <= 1'b0;
			scalar_data <= '0;
			cond        <= 1'b0;
		end else begin
			rf_write  <= exec_valid ? wr_next : '0;
			flow      <= exec_valid ? flow_next : '0;
			scalar_we <= exec_valid & movs;
			if (exec_valid && movs)
				scalar_data <= src1_data;
			if (exec_valid && cond_we)
				cond <= cond_next;
		end
	end

endmodule

// ==== hw/instr_sequencer.sv ====
// Program counter and the fetch, read, execute, write-back step sequence
`timescale 1ns/1ps

module instr_sequencer #(
	parameter int INSTR_ADDR_W = 10
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     go,
	input  logic [INSTR_ADDR_W-1:0]  start_pc,
	output logic                     busy,
	output logic                     term,
	output logic                     instr_re,
	output logic [INSTR_ADDR_W-1:0]  instr_addr,
	input  scalar_pkg::instr_t       instr,
	output scalar_pkg::rf_read_t     rf_read,
	output logic                     exec_valid,
	output scalar_pkg::instr_t       exec_instr,
	input  scalar_pkg::flow_t        flow
);
	import scalar_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_F,
		S_R,
		S_E,
		S_W
	} step_t;

	step_t                   state;
	logic [INSTR_ADDR_W-1:0] pc;
	instr_t                  instr_q;

	assign busy       = state != S_IDLE;
	assign instr_re   = state == S_F;
	assign instr_addr = pc;

	// Memory data arrives during R, straight to the bank read ports
	assign rf_read.src1 = instr.src1;
	assign rf_read.src2 = instr.src2;

	assign exec_valid = state == S_E;
	assign exec_instr = instr_q;

	always_ff @(posedge clock) begin
		if (state == S_R)
			instr_q <= instr;
	end

	//////////////////////////////////////////////////
	// Step FSM and PC
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			pc    <= '0;
			term  <= 1'b0;
		end else begin
			term <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go) begin
						pc    <= start_pc;
						state <= S_F;
					end
				end
				S_F: state <= S_R;
				S_R: state <= S_E;
				S_E: state <= S_W;
				S_W: begin
					if (flow.redirect)
						pc <= flow.target[INSTR_ADDR_W-1:0];
					else
						pc <= pc + 1'b1;
					if (flow.term) begin
						term  <= 1'b1;
						state <= S_IDLE;
					end else begin
						state <= S_F;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/wb_ctrl_regs.sv ====
// Wishbone classic slave with control, start address, status and scalar result
`timescale 1ns/1ps

module wb_ctrl_regs #(
	parameter int INSTR_ADDR_W = 10
) (
	input  logic                            clock,
	input  logic                            reset,
	input  scalar_pkg::wb_req_t             wb_req,
	output scalar_pkg::wb_rsp_t             wb_rsp,
	input  logic                            busy,
	input  logic                            term,
	input  logic                            scalar_we,
	input  logic [scalar_pkg::DATA_W-1:0]   scalar_data,
	output logic                            go,
	output logic [INSTR_ADDR_W-1:0]         start_pc
);
	import scalar_pkg::*;

	logic              access;
	logic              wr_access;
	logic              done;
	logic [DATA_W-1:0] scalar_q;
	logic [DATA_W-1:0] rd_data;

	// One ack per request, none right after the previous one
	assign access    = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
	assign wr_access = access & wb_req.we;

	always_comb begin
		case (wb_req.adr)
			REG_START_PC: rd_data = DATA_W'(start_pc);
			REG_STATUS:   rd_data = {{(DATA_W-2){1'b0}}, done, busy};
			REG_SCALAR:   rd_data = scalar_q;
			default:      rd_data = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Bus response
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_rsp <= '0;
		end else begin
			wb_rsp.ack <= access;
			if (access && !wb_req.we)
				wb_rsp.dat <= rd_data;
		end
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			go       <= 1'b0;
			done     <= 1'b0;
			start_pc <= '0;
			scalar_q <= '0;
		end else begin
			// Start only from idle
			go <= wr_access && wb_req.adr == REG_CONTROL && wb_req.dat[0] && !busy;
			if (wr_access && wb_req.adr == REG_START_PC)
				start_pc <= wb_req.dat[INSTR_ADDR_W-1:0];
			if (go)
				done <= 1'b0;
			else if (term)
				done <= 1'b1;
			if (scalar_we)
				scalar_q <= scalar_data;
		end
	end

endmodule

// ==== hw/scalar_core_top.sv ====
// Scalar core top level joining host registers, sequencer, register file and ALU
`timescale 1ns/1ps

module scalar_core_top #(
	parameter int INSTR_ADDR_W = 10
) (
	input  logic                     clock,
	input  logic                     reset,
	input  scalar_pkg::wb_req_t      wb_req,
	output scalar_pkg::wb_rsp_t      wb_rsp,
	output logic                     instr_re,
	output logic [INSTR_ADDR_W-1:0]  instr_addr,
	input  scalar_pkg::instr_t       instr
);
	import scalar_pkg::*;

	logic                    go;
	logic                    busy;
	logic                    term;
	logic [INSTR_ADDR_W-1:0] start_pc;

	rf_read_t          rf_read;
	rf_write_t         rf_write;
	logic [DATA_W-1:0] src1_data;
	logic [DATA_W-1:0] src2_data;

	logic              exec_valid;
	instr_t            exec_instr;
	flow_t             flow;
	logic              scalar_we;
	logic [DATA_W-1:0] scalar_data;

	wb_ctrl_regs #(.INSTR_ADDR_W(INSTR_ADDR_W)) u_wb_ctrl_regs (
		.clock       (clock),
		.reset       (reset),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.busy        (busy),
		.term        (term),
		.scalar_we   (scalar_we),
		.scalar_data (scalar_data),
		.go          (go),
		.start_pc    (start_pc)
	);

	instr_sequencer #(.INSTR_ADDR_W(INSTR_ADDR_W)) u_instr_sequencer (
		.clock      (clock),
		.reset      (reset),
		.go         (go),
		.start_pc   (start_pc),
		.busy       (busy),
		.term       (term),
		.instr_re   (instr_re),
		.instr_addr (instr_addr),
		.instr      (instr),
		.rf_read    (rf_read),
		.exec_valid (exec_valid),
		.exec_instr (exec_instr),
		.flow       (flow)
	);

	reg_file u_reg_file (
		.clock     (clock),
		.reset     (reset),
		.rf_read   (rf_read),
		.rf_write  (rf_write),
		.src1_data (src1_data),
		.src2_data (src2_data)
	);

	exec_unit #(.INSTR_ADDR_W(INSTR_ADDR_W)) u_exec_unit (
		.clock       (clock),
		.reset       (reset),
		.exec_valid  (exec_valid),
		.exec_instr  (exec_instr),
		.src1_data   (src1_data),
		.src2_data   (src2_data),
		.rf_write    (rf_write),
		.flow        (flow),
		.scalar_we   (scalar_we),
		.scalar_data (scalar_data)
	);

endmodule

// ==== bench/scalar_core_assert.sv ====
// Protocol assertions on the instruction sequencer step handshakes
`timescale 1ns/1ps

module scalar_core_assert (
	input logic clock,
	input logic reset,
	input logic busy,
	input logic term,
	input logic instr_re,
	input logic exec_valid
);
	int failures = 0;

	fetch_when_busy: assert property (@(posedge clock) disable iff (reset)
		instr_re |-> busy)
	else begin
		$error("instr_re high while the sequencer is idle");
		failures++;
	end

	term_pulse: assert property (@(posedge clock) disable iff (reset)
		term |=> !term && !busy)
	else begin
		$error("term longer than one cycle or busy right after term");
		failures++;
	end

	// At most one execute step per instruction
	exec_spacing: assert property (@(posedge clock) disable iff (reset)
		exec_valid |=> !exec_valid)
	else begin
		$error("exec_valid on two cycles in a row");
		failures++;
	end

endmodule

bind instr_sequencer scalar_core_assert u_seq_assert (
	.clock      (clock),
	.reset      (reset),
	.busy       (busy),
	.term       (term),
	.instr_re   (instr_re),
	.exec_valid (exec_valid)
);

// ==== bench/tb_encode.svh ====
// Instruction encoding and reference ALU rules for the scalar core testbench
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic instr_t make_instr(input op_t op, input logic [REG_IDX_W-1:0] dst,
		input logic [REG_IDX_W-1:0] src1, input logic [REG_IDX_W-1:0] src2,
		input logic [IMM_W-1:0] imm);
	instr_t word;
	word.op   = op;
	word.dst  = dst;
	word.src1 = src1;
	word.src2 = src2;
	word.imm  = imm;
	return word;
endfunction

function automatic logic writes_reg(input op_t op);
	return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI};
endfunction

// dst value of a register-writing instruction
function automatic logic [DATA_W-1:0] alu_model(input op_t op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [IMM_W-1:0] imm);
	case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_XOR:  return a ^ b;
		OP_ADDI: return a + {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
		default: return '0;
	endcase
endfunction

`endif

// ==== bench/tb_scalar_core.sv ====
// Directed testbench for the scalar core with instruction memory model and Wishbone host
`timescale 1ns/1ps

module tb_scalar_core;
	import scalar_pkg::*;

	`include "tb_encode.svh"

	localparam int ADDR_W    = 10;
	localparam int MEM_DEPTH = 1 << ADDR_W;
	// Longest run is under 300 instructions of 4 cycles, plus bus polling
	localparam int MAX_CYCLES = 20000;

	logic              clock;
	logic              reset;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic              instr_re;
	logic [ADDR_W-1:0] instr_addr;
	instr_t            instr;

	instr_t            imem [MEM_DEPTH];
	logic [DATA_W-1:0] model_regs [1 << REG_IDX_W];
	logic [ADDR_W-1:0] load_addr;
	logic [31:0]       rng_state;
	int                start_id;
	int                seen_id;
	int                fetch_count;
	int                cycles;
	logic [ADDR_W-1:0] start_addr;
	logic [ADDR_W-1:0] last_addr;
	instr_t            last_instr;
	logic              req_valid;

	scalar_core_top #(.INSTR_ADDR_W(ADDR_W)) u_scalar_core_top (
		.clock      (clock),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.instr_re   (instr_re),
		.instr_addr (instr_addr),
		.instr      (instr)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles = cycles + 1;
		end
		$display("Timeout after %0d cycles without the run finishing", cycles);
		abort_run();
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("FAILED at %0d ns: %s = 0x%08h, expected 0x%08h",
				$time, name, got, expected);
			abort_run();
		end
	endtask

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	//////////////////////////////////////////////////
	// Instruction memory, one cycle read latency
	//////////////////////////////////////////////////
	task automatic check_fetch(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] next_addr;
		logic [ADDR_W-1:0] target;
		next_addr = last_addr + 1'b1;
		target    = last_instr.imm[ADDR_W-1:0];
		if (seen_id != start_id) begin
			next_addr = start_addr;
			target    = start_addr;
		end else if (last_instr.op == OP_JMP) begin
			next_addr = target;
		end else if (last_instr.op != OP_BRC) begin
			target = next_addr;
		end
		assert (addr == next_addr || addr == target) else begin
			$display("FAILED at %0d ns: instr_addr = %0d, expected %0d or %0d",
				$time, addr, next_addr, target);
			abort_run();
		end
		seen_id     = start_id;
		last_addr   = addr;
		last_instr  = imem[addr];
		fetch_count = fetch_count + 1;
	endtask

	initial begin
		seen_id     = 0;
		fetch_count = 0;
		req_valid   = 1'b0;
		forever begin
			@(negedge clock);
			req_valid = instr_re;
			if (instr_re)
				check_fetch(instr_addr);
		end
	end

	initial begin
		instr = '0;
		forever begin
			@(posedge clock);
			#10;
			if (req_valid)
				instr = imem[last_addr];
		end
	end

	always @(negedge clock) begin
		assert (u_scalar_core_top.u_instr_sequencer.u_seq_assert.failures == 0) else begin
			$display("A sequencer protocol assertion failed");
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// Host bus and program loading
	//////////////////////////////////////////////////
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
			output logic [31:0] rdata);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		do begin
			@(posedge clock);
			#10;
		end while (!wb_rsp.ack);
		rdata  = wb_rsp.dat;
		wb_req = '0;
		// Idle cycle between requests
		@(posedge clock);
		#10;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	task automatic emit(input op_t op, input int dst, input int src1, input int src2,
			input int imm);
		logic [REG_IDX_W-1:0] d;
		logic [REG_IDX_W-1:0] s1;
		logic [REG_IDX_W-1:0] s2;
		d  = REG_IDX_W'(dst);
		s1 = REG_IDX_W'(src1);
		s2 = REG_IDX_W'(src2);
		imem[load_addr] = make_instr(op, d, s1, s2, IMM_W'(imm));
		// Register model is only exact for straight-line code
		if (writes_reg(op))
			model_regs[d] = alu_model(op, model_regs[s1], model_regs[s2], IMM_W'(imm));
		load_addr = load_addr + 1'b1;
	endtask

	// Count r10 up to limit, JMP over a poison MOVS
	task automatic load_loop(input int base, input int limit);
		load_addr = ADDR_W'(base);
		emit(OP_ADDI, 10, 0, 0, 0);
		emit(OP_ADDI, 11, 0, 0, limit);
		emit(OP_ADDI, 12, 0, 0, 'h555);
		emit(OP_ADDI, 10, 10, 0, 1);
		emit(OP_CMPLT, 0, 10, 11, 0);
		emit(OP_BRC, 0, 0, 0, (base + 3) % MEM_DEPTH);
		emit(OP_MOVS, 0, 10, 0, 0);
		emit(OP_JMP, 0, 0, 0, (base + 9) % MEM_DEPTH);
		emit(OP_MOVS, 0, 12, 0, 0);
		emit(OP_TERM, 0, 0, 0, 0);
	endtask

	task automatic start_program(input int base);
		wb_write(REG_START_PC, base);
		start_addr = ADDR_W'(base);
		start_id   = start_id + 1;
		wb_write(REG_CONTROL, 32'd1);
	endtask

	task automatic finish_program(input logic [31:0] expected);
		logic [31:0] value;
		do
			wb_read(REG_STATUS, value);
		while (!value[1]);
		check_value("wb_rsp.dat (STATUS)", value, 32'h2);
		assert (seen_id == start_id) else begin
			$display("No instruction was fetched after go");
			abort_run();
		end
		wb_read(REG_SCALAR, value);
		check_value("wb_rsp.dat (SCALAR)", value, expected);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic test_reset_values();
		logic [31:0] value;
		logic [31:0] pc_value;
		wb_read(REG_STATUS, value);
		check_value("wb_rsp.dat (STATUS)", value, '0);
		wb_read(REG_SCALAR, value);
		check_value("wb_rsp.dat (SCALAR)", value, '0);
		pc_value = next_random();
		wb_write(REG_START_PC, pc_value);
		wb_read(REG_START_PC, value);
		check_value("wb_rsp.dat (START_PC)", value, 32'(pc_value[ADDR_W-1:0]));
	endtask

	// Operands from both banks, in mixed and same-bank pairs
	task automatic test_arith();
		load_addr = '0;
		emit(OP_ADDI, 2, 0, 0, next_random());
		emit(OP_ADDI, 3, 0, 0, next_random());
		emit(OP_ADDI, 4, 2, 0, next_random());
		emit(OP_ADDI, 5, 3, 0, next_random());
		emit(OP_ADD, 6, 2, 3, 0);
		emit(OP_SUB, 7, 6, 5, 0);
		emit(OP_AND, 9, 7, 4, 0);
		emit(OP_XOR, 8, 9, 3, 0);
		emit(OP_SUB, 13, 8, 6, 0);
		emit(OP_MOVS, 0, 13, 0, 0);
		emit(OP_TERM, 0, 0, 0, 0);
		start_program(0);
		finish_program(model_regs[13]);
	endtask

	task automatic test_loop(input int base);
		int limit;
		limit = 10 + int'(next_random() & 32'h1f);
		load_loop(base, limit);
		start_program(base);
		finish_program(32'(limit));
	endtask

	task automatic test_go_while_busy();
		int          first;
		logic [31:0] status;
		load_loop(300, 90);
		first = fetch_count;
		start_program(300);
		while (fetch_count < first + 20) begin
			@(posedge clock);
			#10;
		end
		wb_write(REG_CONTROL, 32'd1);
		wb_read(REG_STATUS, status);
		check_value("wb_rsp.dat (STATUS)", status, 32'h1);
		finish_program(32'd90);
	endtask

	initial begin
		reset      = 1'b1;
		wb_req     = '0;
		start_id   = 0;
		start_addr = '0;
		load_addr  = '0;
		rng_state  = 32'd67078;
		model_regs = '{default: '0};
		for (int a = 0; a < MEM_DEPTH; a++)
			imem[ADDR_W'(a)] = make_instr(OP_NOP, '0, '0, '0, IMM_W'(a));
		repeat (5) @(posedge clock);
		#10;
		reset = 1'b0;

		test_reset_values();
		test_arith();
		test_loop(0);
		// Loop placed across the top of memory so the PC wraps
		test_loop(MEM_DEPTH - 6);
		test_go_while_busy();

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+bench
hw/scalar_pkg.sv
hw/reg_bank.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/instr_sequencer.sv
hw/wb_ctrl_regs.sv
hw/scalar_core_top.sv
bench/scalar_core_assert.sv
bench/tb_scalar_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scalar_core
OBJ_DIR   ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) bench/tb_encode.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
